/* source/lane_isa_pkg.sv */
`default_nettype none

package lane_isa_pkg;

    localparam int WORD_W     = 32;   // Datapath width
    localparam int REG_ADDR_W = 5;    // 32 registers per thread
    localparam int THREAD_W   = 4;    // Up to 16 threads
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [THREAD_W-1:0]   thread_id_t;

    // Integer ops in the low half, float ops above
    // is_float still picks the unit, the split just keeps codes unique
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_SLL  = 4'h5,
        OP_SRL  = 4'h6,
        OP_SLT  = 4'h7,   // Signed compare, 1 or 0
        OP_FMIN = 4'h8,
        OP_FMAX = 4'h9,
        OP_FNEG = 4'ha,   // b ignored
        OP_FABS = 4'hb,   // b ignored
        OP_FEQ  = 4'hc,   // Exact bit compare
        OP_FLT  = 4'hd    // Sign-magnitude order, -0 below +0
    } op_t;

    // Decoded instruction as pushed by the host
    typedef struct packed {
        thread_id_t thread;
        op_t        op;
        logic       is_float;
        logic       use_imm;   // Second operand from imm instead of rs2
        word_t      imm;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic       we;        // Result goes to rd
    } instr_t;

endpackage

`default_nettype wire

/* source/lane_pipe_pkg.sv */
`default_nettype none

package lane_pipe_pkg;

    import lane_isa_pkg::*;

    // ID to EX, operands already resolved
    typedef struct packed {
        word_t      operand1;
        word_t      operand2;   // Register data or immediate
        op_t        op;
        logic       is_float;
        reg_addr_t  rd;
        logic       we;
        thread_id_t thread;
        logic       valid;
    } id_ex_t;

    // Shared by EX/MEM and MEM/WB since MEM is a pass-through
    typedef struct packed {
        word_t      result;
        reg_addr_t  rd;
        logic       we;
        thread_id_t thread;
        logic       valid;
    } ex_wb_t;

endpackage

`default_nettype wire

/* source/lane_ifaces.sv */
`default_nettype none

// Queue head towards the lane
interface issue_if
    import lane_isa_pkg::*;
();
    instr_t head;    // Valid whenever empty is low
    logic   empty;
    logic   pop;     // Head retired on this edge
    logic   stall;   // ID stage holding the head

    modport queue (output head, output empty, input pop, input stall);
    modport lane  (input head, input empty, output pop, output stall);
endinterface

// Lane operand reads and writeback
interface rf_if
    import lane_isa_pkg::*;
();
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    thread_id_t rd_thread;
    word_t      rdata1;
    word_t      rdata2;
    reg_addr_t  wr_addr;
    word_t      wr_data;
    thread_id_t wr_thread;
    logic       wr_en;
    logic       wb_stall;   // Host owns the write port this cycle

    modport lane (
        output rs1, rs2, rd_thread, wr_addr, wr_data, wr_thread, wr_en,
        input  rdata1, rdata2, wb_stall
    );
    modport regfile (
        input  rs1, rs2, rd_thread, wr_addr, wr_data, wr_thread, wr_en,
        output rdata1, rdata2, wb_stall
    );
endinterface

`default_nettype wire

/* source/instr_queue.sv */
`default_nettype none

module instr_queue #(
    parameter type T           = logic [31:0],
    parameter int  QUEUE_DEPTH = 4
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    push_i,
    input  T        data_i,
    output logic    full_o,
    issue_if.queue  issue
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    T                 entries [QUEUE_DEPTH];   // Payload storage, no reset
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign full_o      = (count == CNT_W'(QUEUE_DEPTH));
    assign issue.empty = (count == '0);
    assign issue.head  = entries[rd_ptr];

    assign do_push = push_i && !full_o;   // Dropped when full
    // Pop only counts when the lane is not holding its ID stage
    assign do_pop  = issue.pop && !issue.empty && !issue.stall;

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/thread_regfile.sv */
`default_nettype none

module thread_regfile
    import lane_isa_pkg::*;
#(
    parameter int NUM_THREADS = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    rf_if.regfile      rf,
    input  logic       host_we_i,
    input  thread_id_t host_thread_i,
    input  reg_addr_t  host_addr_i,
    input  word_t      host_wdata_i,
    input  thread_id_t host_rthread_i,
    input  reg_addr_t  host_raddr_i,
    output word_t      host_rdata_o
);

    localparam int TIDX_W = (NUM_THREADS > 1) ? $clog2(NUM_THREADS) : 1;

    word_t regs [NUM_THREADS][NUM_REGS];

    // x0 is hardwired, whatever was stored there
    function automatic word_t read_reg(thread_id_t t, reg_addr_t a);
        return (a == '0) ? '0 : regs[t[TIDX_W-1:0]][a];
    endfunction

    assign rf.rdata1    = read_reg(rf.rd_thread, rf.rs1);
    assign rf.rdata2    = read_reg(rf.rd_thread, rf.rs2);
    assign host_rdata_o = read_reg(host_rthread_i, host_raddr_i);

    assign rf.wb_stall = host_we_i;   // Host wins the write port

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int t = 0; t < NUM_THREADS; t++) begin
                for (int r = 0; r < NUM_REGS; r++) begin
                    regs[t][r] <= '0;
                end
            end
        end else if (host_we_i) begin
            regs[host_thread_i[TIDX_W-1:0]][host_addr_i] <= host_wdata_i;
        end else if (rf.wr_en) begin
            regs[rf.wr_thread[TIDX_W-1:0]][rf.wr_addr] <= rf.wr_data;   // Lane writeback
        end
    end

endmodule

`default_nettype wire

/* source/exec_unit.sv */
`default_nettype none

module exec_unit
    import lane_isa_pkg::*;
(
    input  op_t   op_i,
    input  logic  is_float_i,
    input  word_t a_i,
    input  word_t b_i,
    output word_t result_o
);

    logic  f_lt;    // a below b in sign-magnitude order
    word_t int_res;
    word_t flt_res;

    // Total order on bit patterns, so -0 sits just below +0
    function automatic logic sm_less(word_t a, word_t b);
        if (a[31] != b[31]) begin
            return a[31];                    // Negative side is smaller
        end else if (!a[31]) begin
            return a[30:0] < b[30:0];
        end else begin
            return a[30:0] > b[30:0];        // Larger magnitude is smaller when negative
        end
    endfunction

    assign f_lt = sm_less(a_i, b_i);

    always_comb begin
        case (op_i)
            OP_ADD:  int_res = a_i + b_i;
            OP_SUB:  int_res = a_i - b_i;
            OP_AND:  int_res = a_i & b_i;
            OP_OR:   int_res = a_i | b_i;
            OP_XOR:  int_res = a_i ^ b_i;
            OP_SLL:  int_res = a_i << b_i[4:0];
            OP_SRL:  int_res = a_i >> b_i[4:0];
            OP_SLT:  int_res = {31'd0, $signed(a_i) < $signed(b_i)};
            default: int_res = '0;            // Float codes on the int unit
        endcase
    end

    always_comb begin
        case (op_i)
            OP_FMIN: flt_res = f_lt ? a_i : b_i;
            OP_FMAX: flt_res = f_lt ? b_i : a_i;
            OP_FNEG: flt_res = {~a_i[31], a_i[30:0]};
            OP_FABS: flt_res = {1'b0, a_i[30:0]};
            OP_FEQ:  flt_res = {31'd0, a_i == b_i};   // Exact, so -0 != +0
            OP_FLT:  flt_res = {31'd0, f_lt};
            default: flt_res = '0;
        endcase
    end

    assign result_o = is_float_i ? flt_res : int_res;

endmodule

`default_nettype wire

/* source/lane_pipeline.sv */
`default_nettype none

module lane_pipeline
    import lane_isa_pkg::*;
    import lane_pipe_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    issue_if.lane issue,
    rf_if.lane    rf,
    output logic  busy_o
);

    id_ex_t id_ex_q;     // EX stage contents
    id_ex_t id_ex_d;
    ex_wb_t ex_mem_q;    // MEM stage contents
    ex_wb_t ex_mem_d;
    ex_wb_t mem_wb_q;    // WB stage contents
    word_t  ex_result;
    logic   raw_hazard;
    logic   id_stall;
    logic   take_head;

    // Older instruction of the same thread still to write a source of the head
    function automatic logic depends_on(logic v, logic we, thread_id_t t, reg_addr_t rd,
                                        instr_t h);
        logic src_hit;
        src_hit = (rd == h.rs1) || (!h.use_imm && (rd == h.rs2));
        return v && we && (t == h.thread) && (rd != '0) && src_hit;
    endfunction

    // WB counts too since its write lands only at the end of this cycle
    assign raw_hazard =
        depends_on(id_ex_q.valid, id_ex_q.we, id_ex_q.thread, id_ex_q.rd, issue.head) ||
        depends_on(ex_mem_q.valid, ex_mem_q.we, ex_mem_q.thread, ex_mem_q.rd, issue.head) ||
        depends_on(mem_wb_q.valid, mem_wb_q.we, mem_wb_q.thread, mem_wb_q.rd, issue.head);

    assign id_stall  = rf.wb_stall || (!issue.empty && raw_hazard);
    assign take_head = !issue.empty && !id_stall;

    assign issue.pop   = take_head;
    assign issue.stall = id_stall;

    // Operand fetch straight from the queue head
    assign rf.rs1       = issue.head.rs1;
    assign rf.rs2       = issue.head.rs2;
    assign rf.rd_thread = issue.head.thread;

    always_comb begin
        id_ex_d.operand1 = rf.rdata1;
        id_ex_d.operand2 = issue.head.use_imm ? issue.head.imm : rf.rdata2;
        id_ex_d.op       = issue.head.op;
        id_ex_d.is_float = issue.head.is_float;
        id_ex_d.rd       = issue.head.rd;
        id_ex_d.we       = issue.head.we;
        id_ex_d.thread   = issue.head.thread;
        id_ex_d.valid    = take_head;     // Bubble on hazard or empty queue
    end

    exec_unit exec0 (
        .op_i       (id_ex_q.op),
        .is_float_i (id_ex_q.is_float),
        .a_i        (id_ex_q.operand1),
        .b_i        (id_ex_q.operand2),
        .result_o   (ex_result)
    );

    always_comb begin
        ex_mem_d.result = ex_result;
        ex_mem_d.rd     = id_ex_q.rd;
        ex_mem_d.we     = id_ex_q.we;
        ex_mem_d.thread = id_ex_q.thread;
        ex_mem_d.valid  = id_ex_q.valid;
    end

    // Whole pipe freezes while the host holds the write port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_ex_q.valid  <= 1'b0;
            ex_mem_q.valid <= 1'b0;
            mem_wb_q.valid <= 1'b0;
        end else if (!rf.wb_stall) begin
            id_ex_q  <= id_ex_d;
            ex_mem_q <= ex_mem_d;
            mem_wb_q <= ex_mem_q;   // MEM has no work, result passes through
        end
    end

    // Writeback
    assign rf.wr_addr   = mem_wb_q.rd;
    assign rf.wr_data   = mem_wb_q.result;
    assign rf.wr_thread = mem_wb_q.thread;
    assign rf.wr_en     = mem_wb_q.valid && mem_wb_q.we && !rf.wb_stall;

    assign busy_o = id_ex_q.valid || ex_mem_q.valid || mem_wb_q.valid;

endmodule

`default_nettype wire

/* source/simt_lane_top.sv */
`default_nettype none

module simt_lane_top
    import lane_isa_pkg::*;
#(
    parameter int QUEUE_DEPTH = 4,
    parameter int NUM_THREADS = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  thread_id_t instr_thread_i,
    input  op_t        instr_op_i,
    input  logic       instr_is_float_i,
    input  logic       instr_use_imm_i,
    input  word_t      instr_imm_i,
    input  reg_addr_t  instr_rs1_i,
    input  reg_addr_t  instr_rs2_i,
    input  reg_addr_t  instr_rd_i,
    input  logic       instr_we_i,
    input  logic       instr_push_i,
    input  logic       host_we_i,
    input  thread_id_t host_thread_i,
    input  reg_addr_t  host_addr_i,
    input  word_t      host_wdata_i,
    input  thread_id_t host_rthread_i,
    input  reg_addr_t  host_raddr_i,
    output logic       queue_full_o,
    output word_t      host_rdata_o,
    output logic       idle_o
);

    instr_t push_instr;
    logic   lane_busy;

    issue_if issue0 ();
    rf_if    rf0 ();

    // Field order follows instr_t
    assign push_instr = '{thread: instr_thread_i, op: instr_op_i, is_float: instr_is_float_i,
                          use_imm: instr_use_imm_i, imm: instr_imm_i, rs1: instr_rs1_i,
                          rs2: instr_rs2_i, rd: instr_rd_i, we: instr_we_i};

    instr_queue #(.T(instr_t), .QUEUE_DEPTH(QUEUE_DEPTH)) queue0 (
        .clk, .rst_n, .push_i(instr_push_i), .data_i(push_instr), .full_o(queue_full_o),
        .issue(issue0)
    );

    lane_pipeline lane0 (.clk, .rst_n, .issue(issue0), .rf(rf0), .busy_o(lane_busy));

    thread_regfile #(.NUM_THREADS(NUM_THREADS)) regfile0 (
        .clk, .rst_n, .rf(rf0), .host_we_i, .host_thread_i, .host_addr_i, .host_wdata_i,
        .host_rthread_i, .host_raddr_i, .host_rdata_o
    );

    assign idle_o = issue0.empty && !lane_busy;   // Nothing queued and nothing in flight

endmodule

`default_nettype wire

/* testbench/lane_ref_model.svh */
`ifndef LANE_REF_MODEL_SVH
`define LANE_REF_MODEL_SVH

// Sequential copy of the register file, sized for every possible thread id
word_t ref_regs [2**THREAD_W][NUM_REGS];

task automatic ref_clear();
    ref_regs = '{default: '0};   // Matches the cleared array after reset
endtask

function automatic word_t ref_read(thread_id_t t, reg_addr_t a);
    return (a == 5'd0) ? 32'd0 : ref_regs[t][a];   // x0 always zero
endfunction

// Sign-magnitude mapped onto an unsigned key with the same order
function automatic word_t order_key(word_t x);
    return x[31] ? ~x : (x | 32'h8000_0000);
endfunction

function automatic word_t ref_exec(op_t op, logic fl, word_t a, word_t b);
    logic  below;
    word_t r;
    below = order_key(a) < order_key(b);
    r     = 32'd0;
    if (fl) begin
        case (op)
            OP_FMIN: r = below ? a : b;
            OP_FMAX: r = below ? b : a;
            OP_FNEG: r = a ^ 32'h8000_0000;     // Flip sign only
            OP_FABS: r = a & 32'h7fff_ffff;
            OP_FEQ:  r = (a == b) ? 32'd1 : 32'd0;
            OP_FLT:  r = below ? 32'd1 : 32'd0;
            default: r = 32'd0;
        endcase
    end else begin
        case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[4:0];
            OP_SRL:  r = a >> b[4:0];
            OP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: r = 32'd0;
        endcase
    end
    return r;
endfunction

// One instruction in program order
task automatic ref_apply(instr_t i);
    word_t a;
    word_t b;
    a = ref_read(i.thread, i.rs1);
    b = i.use_imm ? i.imm : ref_read(i.thread, i.rs2);
    if (i.we) begin
        ref_regs[i.thread][i.rd] = ref_exec(i.op, i.is_float, a, b);
    end
endtask

`endif

/* testbench/lane_tb.sv */
`default_nettype none

module lane_tb
    import lane_isa_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int    CLK_PERIOD      = 10;
    localparam int    TB_THREADS      = 4;
    localparam int    TABLE_LEN       = 21;
    localparam int    HOLD_PUSHES     = 10;   // Pushes made while the host owns the write port
    localparam int    WATCHDOG_CYCLES = 2 * TABLE_LEN * 40 + 1500;
    localparam word_t HOLD_DATA       = 32'h5a5a_0031;

    logic       clk;
    logic       rst_n;
    instr_t     cur_instr;       // Fields go straight to the plain ports
    logic       instr_push;
    logic       host_we;
    thread_id_t host_thread;
    reg_addr_t  host_addr;
    word_t      host_wdata;
    thread_id_t host_rthread;
    reg_addr_t  host_raddr;
    logic       queue_full;
    word_t      host_rdata;
    logic       idle;
    instr_t     stim [TABLE_LEN];
    integer     seed;
    logic       saw_full;

    `include "lane_ref_model.svh"

    simt_lane_top #(.QUEUE_DEPTH(4), .NUM_THREADS(TB_THREADS)) dut0 (
        .clk, .rst_n,
        .instr_thread_i(cur_instr.thread), .instr_op_i(cur_instr.op),
        .instr_is_float_i(cur_instr.is_float), .instr_use_imm_i(cur_instr.use_imm),
        .instr_imm_i(cur_instr.imm), .instr_rs1_i(cur_instr.rs1), .instr_rs2_i(cur_instr.rs2),
        .instr_rd_i(cur_instr.rd), .instr_we_i(cur_instr.we), .instr_push_i(instr_push),
        .host_we_i(host_we), .host_thread_i(host_thread), .host_addr_i(host_addr),
        .host_wdata_i(host_wdata), .host_rthread_i(host_rthread), .host_raddr_i(host_raddr),
        .queue_full_o(queue_full), .host_rdata_o(host_rdata), .idle_o(idle)
    );

    task automatic stop_failed();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("FAILED %0t %s expected %h got %h", $time, name, exp, act);
            stop_failed();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("FAILED %0t %s expected %b got %b", $time, name, exp, act);
            stop_failed();
        end
    endtask

    function automatic instr_t make_instr(thread_id_t t, op_t op, logic fl, logic ui,
                                          reg_addr_t rs1, reg_addr_t rs2, word_t imm,
                                          reg_addr_t rd);
        return '{thread: t, op: op, is_float: fl, use_imm: ui, imm: imm, rs1: rs1,
                 rs2: rs2, rd: rd, we: 1'b1};
    endfunction

    // Threads interleave; last four form a back-to-back chain in thread 0
    function automatic void fill_table();
        stim[0]  = make_instr(4'd0, OP_ADD,  1'b0, 1'b0, 5'd1,  5'd2,  32'd0,         5'd5);
        stim[1]  = make_instr(4'd1, OP_SUB,  1'b0, 1'b1, 5'd3,  5'd0,  32'h123,       5'd6);
        stim[2]  = make_instr(4'd2, OP_AND,  1'b0, 1'b0, 5'd4,  5'd5,  32'd0,         5'd7);
        stim[3]  = make_instr(4'd3, OP_OR,   1'b0, 1'b1, 5'd1,  5'd0,  32'hf0f0_0000, 5'd8);
        stim[4]  = make_instr(4'd0, OP_XOR,  1'b0, 1'b0, 5'd2,  5'd3,  32'd0,         5'd9);
        stim[5]  = make_instr(4'd1, OP_SLL,  1'b0, 1'b1, 5'd4,  5'd0,  32'h27,        5'd10);
        stim[6]  = make_instr(4'd2, OP_SRL,  1'b0, 1'b0, 5'd6,  5'd1,  32'd0,         5'd11);
        stim[7]  = make_instr(4'd3, OP_SLT,  1'b0, 1'b0, 5'd2,  5'd3,  32'd0,         5'd12);
        stim[8]  = make_instr(4'd1, OP_SLT,  1'b0, 1'b1, 5'd1,  5'd0,  32'hffff_fff0, 5'd0);
        stim[9]  = make_instr(4'd0, OP_FMIN, 1'b1, 1'b1, 5'd0,  5'd0,  32'h8000_0000, 5'd15);
        stim[10] = make_instr(4'd1, OP_FMAX, 1'b1, 1'b1, 5'd0,  5'd0,  32'h8000_0000, 5'd16);
        stim[11] = make_instr(4'd2, OP_FNEG, 1'b1, 1'b0, 5'd0,  5'd0,  32'd0,         5'd17);
        stim[12] = make_instr(4'd2, OP_FLT,  1'b1, 1'b1, 5'd17, 5'd0,  32'd0,         5'd18);
        stim[13] = make_instr(4'd2, OP_FEQ,  1'b1, 1'b1, 5'd17, 5'd0,  32'd0,         5'd19);
        stim[14] = make_instr(4'd3, OP_FABS, 1'b1, 1'b0, 5'd1,  5'd0,  32'd0,         5'd20);
        stim[15] = make_instr(4'd3, OP_FMIN, 1'b1, 1'b0, 5'd1,  5'd2,  32'd0,         5'd21);
        stim[16] = make_instr(4'd1, OP_FLT,  1'b1, 1'b0, 5'd2,  5'd3,  32'd0,         5'd22);
        stim[17] = make_instr(4'd0, OP_ADD,  1'b0, 1'b1, 5'd1,  5'd0,  32'd1,         5'd25);
        stim[18] = make_instr(4'd0, OP_SLL,  1'b0, 1'b1, 5'd25, 5'd0,  32'd3,         5'd25);
        stim[19] = make_instr(4'd0, OP_SUB,  1'b0, 1'b0, 5'd25, 5'd1,  32'd0,         5'd26);
        stim[20] = make_instr(4'd0, OP_SLT,  1'b0, 1'b0, 5'd26, 5'd25, 32'd0,         5'd27);
    endfunction

    task automatic preload_regs();
        word_t val;
        for (int t = 0; t < TB_THREADS; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                @(posedge clk);
                val = $random(seed);
                host_we     <= 1'b1;
                host_thread <= thread_id_t'(t);
                host_addr   <= reg_addr_t'(r);
                host_wdata  <= val;   // x0 written too and still reads zero
                ref_regs[t][r] = val;
            end
        end
        @(posedge clk);
        host_we <= 1'b0;
    endtask

    task automatic check_all_regs();
        for (int t = 0; t < TB_THREADS; t++) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                @(posedge clk);
                host_rthread <= thread_id_t'(t);
                host_raddr   <= reg_addr_t'(r);
                @(negedge clk);   // Read port settled
                check_word($sformatf("host_rdata_o t%0d x%0d", t, r),
                           ref_read(thread_id_t'(t), reg_addr_t'(r)), host_rdata);
            end
        end
    endtask

    // Full seen between the edges is the value the queue uses at the next edge
    task automatic run_table(int hold);
        saw_full = 1'b0;
        if (hold > 0) begin
            ref_regs[3][31] = HOLD_DATA;   // Register no table entry touches
        end
        for (int i = 0; i < TABLE_LEN; i++) begin
            @(posedge clk);
            cur_instr   <= stim[i];
            instr_push  <= 1'b1;
            host_we     <= (i < hold);
            host_thread <= 4'd3;
            host_addr   <= 5'd31;
            host_wdata  <= HOLD_DATA;
            @(negedge clk);
            if (queue_full) begin
                saw_full = 1'b1;   // Dropped push
            end else begin
                ref_apply(stim[i]);
            end
        end
        @(posedge clk);
        instr_push <= 1'b0;
        host_we    <= 1'b0;
        @(negedge clk);
        while (!idle) begin
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout, the lane did not drain within the expected time");
        stop_failed();
    end

    initial begin
        rst_n        = 1'b0;
        cur_instr    = '0;
        instr_push   = 1'b0;
        host_we      = 1'b0;
        host_thread  = '0;
        host_addr    = '0;
        host_wdata   = '0;
        host_rthread = '0;
        host_raddr   = '0;
        seed         = 58315;
        saw_full     = 1'b0;
        ref_clear();
        fill_table();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag("idle_o", 1'b1, idle);
        check_flag("queue_full_o", 1'b0, queue_full);
        preload_regs();
        check_all_regs();            // Readback of the preload
        run_table(0);
        check_all_regs();            // Integer, float and chained results
        run_table(HOLD_PUSHES);      // Host stalls the lane while the queue fills
        check_flag("queue_full_o seen", 1'b1, saw_full);
        check_flag("queue_full_o", 1'b0, queue_full);
        check_all_regs();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+testbench
source/lane_isa_pkg.sv
source/lane_pipe_pkg.sv
source/lane_ifaces.sv
source/instr_queue.sv
source/thread_regfile.sv
source/exec_unit.sv
source/lane_pipeline.sv
source/simt_lane_top.sv
testbench/lane_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SIMT lane testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --timescale 1ns/1ps --top-module lane_tb \
        -f filelist.f -Mdir obj_dir -o lane_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/lane_sim; then
    echo "Simulation reported failure"
    exit 1
fi

exit 0
